//--- sim.f
src/mem_pkg.sv
src/mem_pg_ctrl.sv
src/mem_access_gate.sv
src/mem_rf_pg_64x16.sv
src/mem_rd_check.sv
src/mem_store_top.sv
verification/mem_store_tb.sv

//--- Bender.yml
package:
  name: mem_store

sources:
  - src/mem_pkg.sv
  - src/mem_pg_ctrl.sv
  - src/mem_access_gate.sv
  - src/mem_rf_pg_64x16.sv
  - src/mem_rd_check.sv
  - src/mem_store_top.sv
  - target: simulation
    files:
      - verification/mem_store_tb.sv

//--- verification/mem_store_tb.sv
// Testbench for the power-gated 64 x 30 store
// Runs power-up, random traffic, parity injection, power loss and
// same-cycle read/write cases against a reference model of the store

`timescale 1ns/1ns
`default_nettype none

module mem_store_tb
    import mem_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    localparam int RAND_TXNS   = 100;
    localparam int WAKE_LIMIT  = 2 * MEM_WAKE_CYCLES + 4;
    localparam int SLEEP_LIMIT = 4;
    localparam int TEST_CYCLES = 5 + 2 * WAKE_LIMIT + 3 * RAND_TXNS + MEM_DEPTH + 60;

    typedef struct packed {
        logic [MEM_DATA_W-1:0] data;
        logic [1:0]            err;
    } exp_rd_s;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  pwr_req;
    logic                  wr_en;
    logic [MEM_ADDR_W-1:0] wr_addr;
    logic [MEM_DATA_W-1:0] wr_data;
    logic [1:0]            wr_par_flip;
    logic                  rd_en;
    logic [MEM_ADDR_W-1:0] rd_addr;
    logic                  pwr_ready;
    logic                  rd_valid;
    logic [MEM_DATA_W-1:0] rd_data;
    logic [1:0]            rd_err;

    // Reference model of the store and of the reads in flight
    logic [MEM_DATA_W-1:0] model_data [MEM_DEPTH];
    logic [1:0]            model_flip [MEM_DEPTH];
    logic [MEM_DEPTH-1:0]  model_valid;
    exp_rd_s               exp_q [$];
    logic                  acc_d1;
    logic                  exp_valid;
    exp_rd_s               exp_rd;
    int                    valid_errs = 0;
    int                    data_errs  = 0;
    int                    err_errs   = 0;
    int                    other_errs = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    mem_store_top u_dut (
        .clk         (clk),
        .reset       (reset),
        .pwr_req     (pwr_req),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_par_flip (wr_par_flip),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .pwr_ready   (pwr_ready),
        .rd_valid    (rd_valid),
        .rd_data     (rd_data),
        .rd_err      (rd_err)
    );

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    // A lost or never written entry is all zero, which checks clean
    function automatic exp_rd_s expect_read(input logic [MEM_ADDR_W-1:0] addr);
        exp_rd_s e;
        e = '0;
        if (model_valid[addr]) begin
            e.data = model_data[addr];
            // A flipped stored parity bit shows up as an error on that half
            e.err  = model_flip[addr];
        end
        return e;
    endfunction

    // Requests count at the edge where the gate sees them with pwr_ready high
    // Reads are looked up before writes, so a same-cycle write is not seen
    // The result is due on the edge after the one where the macro reads
    always @(posedge clk) begin
        if (reset) begin
            model_valid = '0;
            exp_q.delete();
            acc_d1    <= 1'b0;
            exp_valid <= 1'b0;
            exp_rd    <= '0;
        end else begin
            exp_valid <= acc_d1;
            if (acc_d1) begin
                exp_rd <= exp_q.pop_front();
            end
            acc_d1 <= rd_en && pwr_ready;
            if (rd_en && pwr_ready) begin
                exp_q.push_back(expect_read(rd_addr));
            end
            if (wr_en && pwr_ready) begin
                model_data[wr_addr]  = wr_data;
                model_flip[wr_addr]  = wr_par_flip;
                model_valid[wr_addr] = 1'b1;
            end
            // Contents are gone once power is withdrawn
            if (!pwr_req) begin
                model_valid = '0;
            end
        end
    end

    // ----------------------------------------
    // Read result checks
    // ----------------------------------------
    assert property (@(posedge clk) disable iff (reset) rd_valid == exp_valid)
    else begin
        $display("FAILED at %0t ns: rd_valid expected %0b actual %0b",
                 $time, $sampled(exp_valid), $sampled(rd_valid));
        valid_errs++;
    end

    assert property (@(posedge clk) disable iff (reset) !rd_valid || rd_data == exp_rd.data)
    else begin
        $display("FAILED at %0t ns: rd_data expected %h actual %h",
                 $time, $sampled(exp_rd.data), $sampled(rd_data));
        data_errs++;
    end

    // Parity errors are only flagged with a valid read and stay low otherwise
    assert property (@(posedge clk) disable iff (reset)
                     rd_err == (exp_valid ? exp_rd.err : 2'b00))
    else begin
        $display("FAILED at %0t ns: rd_err expected %b actual %b",
                 $time, $sampled(exp_valid) ? $sampled(exp_rd.err) : 2'b00,
                 $sampled(rd_err));
        err_errs++;
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------
    function automatic logic [MEM_ADDR_W-1:0] rand_addr();
        logic [31:0] r;
        r = $urandom;
        return r[MEM_ADDR_W-1:0];
    endfunction

    function automatic logic [MEM_DATA_W-1:0] rand_data();
        logic [31:0] r;
        r = $urandom;
        return r[MEM_DATA_W-1:0];
    endfunction

    // One clock of bus activity
    task automatic drive_cycle(input logic we, input logic [MEM_ADDR_W-1:0] wa,
                               input logic [MEM_DATA_W-1:0] wd, input logic [1:0] flip,
                               input logic re, input logic [MEM_ADDR_W-1:0] ra);
        @(posedge clk);
        wr_en       <= we;
        wr_addr     <= wa;
        wr_data     <= wd;
        wr_par_flip <= flip;
        rd_en       <= re;
        rd_addr     <= ra;
    endtask

    // Waits for pwr_ready to reach a level, optionally firing reads meanwhile
    task automatic wait_ready(input logic level, input int limit, input logic probe);
        int n;
        n = 0;
        while (pwr_ready !== level && n <= limit) begin
            drive_cycle(1'b0, '0, '0, 2'b00, probe, rand_addr());
            n++;
        end
        if (pwr_ready !== level) begin
            $display("pwr_ready did not reach %0b within %0d cycles", level, limit);
            other_errs++;
        end
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        logic [MEM_ADDR_W-1:0] a;
        logic [MEM_DATA_W-1:0] d;
        void'($urandom(32039));
        reset       <= 1'b1;
        pwr_req     <= 1'b1;
        wr_en       <= 1'b0;
        wr_addr     <= '0;
        wr_data     <= '0;
        wr_par_flip <= 2'b00;
        rd_en       <= 1'b0;
        rd_addr     <= '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        // Reads during the wake must all be dropped
        wait_ready(1'b1, WAKE_LIMIT, 1'b1);

        // Entries not written since power-up
        for (int i = 0; i < 4; i++) begin
            drive_cycle(1'b0, '0, '0, 2'b00, 1'b1, rand_addr());
        end

        // Random write then read, with an extra back-to-back read every fourth time
        for (int i = 0; i < RAND_TXNS; i++) begin
            a = rand_addr();
            drive_cycle(1'b1, a, rand_data(), 2'b00, 1'b0, '0);
            drive_cycle(1'b0, '0, '0, 2'b00, 1'b1, a);
            if (i % 4 == 3) begin
                drive_cycle(1'b0, '0, '0, 2'b00, 1'b1, rand_addr());
            end
        end

        // Parity injection on the low half, the high half and both
        for (int f = 1; f < 4; f++) begin
            a = rand_addr();
            drive_cycle(1'b1, a, rand_data(), f[1:0], 1'b0, '0);
            drive_cycle(1'b0, '0, '0, 2'b00, 1'b1, a);
        end

        // Same-cycle read and write of one entry, then a read of the new word
        a = rand_addr();
        d = rand_data();
        drive_cycle(1'b1, a, rand_data(), 2'b00, 1'b0, '0);
        drive_cycle(1'b1, a, d, 2'b00, 1'b1, a);
        drive_cycle(1'b0, '0, '0, 2'b00, 1'b1, a);

        // Power down with an idle bus, then traffic that has to be dropped
        drive_cycle(1'b0, '0, '0, 2'b00, 1'b0, '0);
        pwr_req <= 1'b0;
        wait_ready(1'b0, SLEEP_LIMIT, 1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_cycle(1'b1, rand_addr(), rand_data(), 2'b00, 1'b1, rand_addr());
        end
        repeat (6) drive_cycle(1'b0, '0, '0, 2'b00, 1'b0, '0);

        // Power back up, every entry must come back as zero
        pwr_req <= 1'b1;
        wait_ready(1'b1, WAKE_LIMIT, 1'b0);
        for (int i = 0; i < MEM_DEPTH; i++) begin
            drive_cycle(1'b0, '0, '0, 2'b00, 1'b1, i[MEM_ADDR_W-1:0]);
        end

        repeat (4) drive_cycle(1'b0, '0, '0, 2'b00, 1'b0, '0);
        if (exp_q.size() != 0) begin
            $display("%0d expected reads never came back", exp_q.size());
            other_errs++;
        end

        $display("Error counts: rd_valid %0d, rd_data %0d, rd_err %0d, other %0d",
                 valid_errs, data_errs, err_errs, other_errs);
        if (valid_errs + data_errs + err_errs + other_errs == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog sized from the planned sequence plus margin
    initial begin
        #(CLK_PERIOD * (TEST_CYCLES + 200));
        $display("Timeout: the run did not finish within %0d cycles", TEST_CYCLES + 200);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/mem_store_top.sv
// Power-gated 64 x 30 store
// Two 64 x 16 macros side by side behind an access gate, with a power-gate
// sequencer driving the macro enable chain and a parity read checker

`timescale 1ns/1ns
`default_nettype none

module mem_store_top
    import mem_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  pwr_req,
    input  wire logic                  wr_en,
    input  wire logic [MEM_ADDR_W-1:0] wr_addr,
    input  wire logic [MEM_DATA_W-1:0] wr_data,
    input  wire logic [1:0]            wr_par_flip,
    input  wire logic                  rd_en,
    input  wire logic [MEM_ADDR_W-1:0] rd_addr,
    output logic                       pwr_ready,
    output logic                       rd_valid,
    output logic      [MEM_DATA_W-1:0] rd_data,
    output logic      [1:0]            rd_err
);

    mem_pwr_s              pwr;
    logic                  chain_mid_b;
    logic                  chain_done_b;
    mem_wr_req_s           wr_lo;
    mem_wr_req_s           wr_hi;
    mem_rd_req_s           rd_req;
    logic                  rd_issue;
    logic [MEM_HALF_W-1:0] rdata_lo;
    logic [MEM_HALF_W-1:0] rdata_hi;

    // ----------------------------------------
    // Power control
    // ----------------------------------------
    mem_pg_ctrl u_pg_ctrl (
        .clk          (clk),
        .reset        (reset),
        .pwr_req      (pwr_req),
        .chain_done_b (chain_done_b),
        .pwr          (pwr),
        .pwr_ready    (pwr_ready)
    );

    mem_access_gate u_gate (
        .clk         (clk),
        .reset       (reset),
        .pwr_ready   (pwr_ready),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_par_flip (wr_par_flip),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .wr_lo       (wr_lo),
        .wr_hi       (wr_hi),
        .rd_req      (rd_req),
        .rd_issue    (rd_issue)
    );

    // ----------------------------------------
    // Macros, enable chain runs low then high
    // ----------------------------------------
    mem_rf_pg_64x16 u_rf_lo (
        .wclk             (clk),
        .rclk             (clk),
        .reset            (reset),
        .we               (wr_lo.we),
        .waddr            (wr_lo.addr),
        .wdata            (wr_lo.half.raw),
        .re               (rd_req.re),
        .raddr            (rd_req.addr),
        .rdata            (rdata_lo),
        .pgcb_isol_en     (pwr.isol_en),
        .pwr_enable_b_in  (pwr.pwr_enable_b),
        .pwr_enable_b_out (chain_mid_b)
    );

    mem_rf_pg_64x16 u_rf_hi (
        .wclk             (clk),
        .rclk             (clk),
        .reset            (reset),
        .we               (wr_hi.we),
        .waddr            (wr_hi.addr),
        .wdata            (wr_hi.half.raw),
        .re               (rd_req.re),
        .raddr            (rd_req.addr),
        .rdata            (rdata_hi),
        .pgcb_isol_en     (pwr.isol_en),
        .pwr_enable_b_in  (chain_mid_b),
        .pwr_enable_b_out (chain_done_b)
    );

    mem_rd_check u_rd_check (
        .clk      (clk),
        .reset    (reset),
        .rd_issue (rd_issue),
        .rdata_lo (rdata_lo),
        .rdata_hi (rdata_hi),
        .rd_valid (rd_valid),
        .rd_data  (rd_data),
        .rd_err   (rd_err)
    );

endmodule

`default_nettype wire

//--- src/mem_rd_check.sv
// Read checker
// Joins the two macro halves into the 30-bit read word, checks the parity
// of each half and aligns the read-valid strobe to the macro output

`timescale 1ns/1ns
`default_nettype none

module mem_rd_check
    import mem_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  rd_issue,
    input  wire logic [MEM_HALF_W-1:0] rdata_lo,
    input  wire logic [MEM_HALF_W-1:0] rdata_hi,
    output logic                       rd_valid,
    output logic      [MEM_DATA_W-1:0] rd_data,
    output logic      [1:0]            rd_err
);

    mem_half_u half_lo;
    mem_half_u half_hi;
    logic      par_bad_lo;
    logic      par_bad_hi;

    // The macros register the read, so valid trails the issue by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_issue;
        end
    end

    assign half_lo.raw = rdata_lo;
    assign half_hi.raw = rdata_hi;

    // Recompute even parity over each data field
    // An all-zero word from a lost or clamped entry checks clean
    assign par_bad_lo = half_lo.f.par ^ (^half_lo.f.data);
    assign par_bad_hi = half_hi.f.par ^ (^half_hi.f.data);

    assign rd_data = {half_hi.f.data, half_lo.f.data};
    // Errors are only reported alongside a valid read
    assign rd_err  = {par_bad_hi, par_bad_lo} & {2{rd_valid}};

endmodule

`default_nettype wire

//--- src/mem_rf_pg_64x16.sv
// Power-gated two-port 64 x 16 register file
// Behavioral model of the macro: one write and one read port, a power
// switch chain that forwards the enable, output isolation and loss of
// contents while the macro is unpowered

`timescale 1ns/1ns
`default_nettype none

module mem_rf_pg_64x16
    import mem_pkg::*;
(
    input  wire logic                  wclk,
    input  wire logic                  rclk,
    input  wire logic                  reset,
    input  wire logic                  we,
    input  wire logic [MEM_ADDR_W-1:0] waddr,
    input  wire logic [MEM_HALF_W-1:0] wdata,
    input  wire logic                  re,
    input  wire logic [MEM_ADDR_W-1:0] raddr,
    output logic      [MEM_HALF_W-1:0] rdata,
    input  wire logic                  pgcb_isol_en,
    input  wire logic                  pwr_enable_b_in,
    output logic                       pwr_enable_b_out
);

    logic [MEM_HALF_W-1:0]      mem [MEM_DEPTH];
    logic [MEM_DEPTH-1:0]       valid;
    logic [MEM_WAKE_CYCLES-1:0] pwr_chain_b;
    logic [MEM_HALF_W-1:0]      rd_q;

    // ----------------------------------------
    // Power switch chain
    // ----------------------------------------
    // The enable ripples through the switch segments and leaves the far
    // end MEM_WAKE_CYCLES later, where it feeds the next macro
    // Reset leaves every segment open
    always_ff @(posedge wclk) begin
        if (reset) begin
            pwr_chain_b <= '1;
        end else begin
            pwr_chain_b <= {pwr_chain_b[MEM_WAKE_CYCLES-2:0], pwr_enable_b_in};
        end
    end

    assign pwr_enable_b_out = pwr_chain_b[MEM_WAKE_CYCLES-1];

    // ----------------------------------------
    // Array contents
    // ----------------------------------------
    // A dark array forgets everything, modelled by one valid bit per entry
    always_ff @(posedge wclk) begin
        if (reset || pwr_enable_b_in) begin
            valid <= '0;
        end else if (we) begin
            valid[waddr] <= 1'b1;
        end
    end

    // Writes only land while the array is powered
    always_ff @(posedge wclk) begin
        if (we && !pwr_enable_b_in) begin
            mem[waddr] <= wdata;
        end
    end

    // ----------------------------------------
    // Read port
    // ----------------------------------------
    // Registered read; a write to the same entry on the same edge is not
    // seen, so the old word comes out
    // Entries lost to a power-off read back as zero
    always_ff @(posedge rclk) begin
        if (re) begin
            rd_q <= valid[raddr] ? mem[raddr] : '0;
        end
    end

    // Isolation clamps the output to zero
    assign rdata = pgcb_isol_en ? '0 : rd_q;

endmodule

`default_nettype wire

//--- src/mem_access_gate.sv
// Access gate
// Accepts writes and reads only while the store is powered, splits each
// write into two parity-protected halves and registers all requests

`timescale 1ns/1ns
`default_nettype none

module mem_access_gate
    import mem_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  pwr_ready,
    input  wire logic                  wr_en,
    input  wire logic [MEM_ADDR_W-1:0] wr_addr,
    input  wire logic [MEM_DATA_W-1:0] wr_data,
    input  wire logic [1:0]            wr_par_flip,
    input  wire logic                  rd_en,
    input  wire logic [MEM_ADDR_W-1:0] rd_addr,
    output mem_wr_req_s                wr_lo,
    output mem_wr_req_s                wr_hi,
    output mem_rd_req_s                rd_req,
    output logic                       rd_issue
);

    logic                  wr_ok;
    logic                  rd_ok;
    logic                  we_q;
    logic                  re_q;
    logic [MEM_ADDR_W-1:0] waddr_q;
    logic [MEM_ADDR_W-1:0] raddr_q;
    mem_half_u             half_lo_d;
    mem_half_u             half_hi_d;
    mem_half_u             half_lo_q;
    mem_half_u             half_hi_q;

    assign wr_ok = wr_en & pwr_ready;
    assign rd_ok = rd_en & pwr_ready;

    // ----------------------------------------
    // Half encode
    // ----------------------------------------
    // Low half carries data bits 14..0, high half bits 29..15
    // Even parity, with an optional flip per half for error injection
    always_comb begin
        half_lo_d.f.data = wr_data[MEM_HALF_W-2:0];
        half_lo_d.f.par  = (^wr_data[MEM_HALF_W-2:0]) ^ wr_par_flip[0];
        half_hi_d.f.data = wr_data[MEM_DATA_W-1:MEM_HALF_W-1];
        half_hi_d.f.par  = (^wr_data[MEM_DATA_W-1:MEM_HALF_W-1]) ^ wr_par_flip[1];
    end

    // Strobes are gated by power and cleared by reset
    always_ff @(posedge clk) begin
        if (reset) begin
            we_q <= 1'b0;
            re_q <= 1'b0;
        end else begin
            we_q <= wr_ok;
            re_q <= rd_ok;
        end
    end

    // Address and data only load on an accepted request
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            waddr_q   <= wr_addr;
            half_lo_q <= half_lo_d;
            half_hi_q <= half_hi_d;
        end
        if (rd_ok) begin
            raddr_q <= rd_addr;
        end
    end

    // Both macros see the same write address and enable
    assign wr_lo    = '{we: we_q, addr: waddr_q, half: half_lo_q};
    assign wr_hi    = '{we: we_q, addr: waddr_q, half: half_hi_q};
    assign rd_req   = '{re: re_q, addr: raddr_q};
    assign rd_issue = re_q;

endmodule

`default_nettype wire

//--- src/mem_pg_ctrl.sv
// Power-gate sequencer
// Orders isolation and the daisy-chained power enable of the macros and
// raises pwr_ready once the enable has passed through the whole chain

`timescale 1ns/1ns
`default_nettype none

module mem_pg_ctrl
    import mem_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     pwr_req,
    input  wire logic     chain_done_b,
    output mem_pwr_s      pwr,
    output logic          pwr_ready
);

    typedef enum logic [1:0] {
        ST_OFF,
        ST_WAKE,
        ST_ON,
        ST_SLEEP
    } pg_state_e;

    pg_state_e state;
    logic      isol_q;
    logic      pwr_en_b_q;

    // ----------------------------------------
    // Sequencer
    // ----------------------------------------
    // Isolation is raised before the enable goes off and dropped only after
    // the last macro reports its switches closed, so it covers every cycle
    // in which some part of the array is dark or still waking
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_OFF;
            isol_q     <= 1'b1;
            pwr_en_b_q <= 1'b1;
            pwr_ready  <= 1'b0;
        end else begin
            case (state)
                ST_OFF: begin
                    // Start the enable down the chain
                    if (pwr_req) begin
                        pwr_en_b_q <= 1'b0;
                        state      <= ST_WAKE;
                    end
                end
                ST_WAKE: begin
                    if (!pwr_req) begin
                        // Request withdrawn mid wake, isolation is still up
                        state <= ST_SLEEP;
                    end else if (!chain_done_b) begin
                        isol_q <= 1'b0;
                        state  <= ST_ON;
                    end
                end
                ST_ON: begin
                    // Ready trails the isolation release by one cycle
                    if (pwr_req) begin
                        pwr_ready <= 1'b1;
                    end else begin
                        pwr_ready <= 1'b0;
                        state     <= ST_SLEEP;
                    end
                end
                ST_SLEEP: begin
                    // First clamp the outputs, then cut the power
                    if (!isol_q) begin
                        isol_q <= 1'b1;
                    end else begin
                        pwr_en_b_q <= 1'b1;
                        state      <= ST_OFF;
                    end
                end
                default: state <= ST_OFF;
            endcase
        end
    end

    assign pwr.isol_en      = isol_q;
    assign pwr.pwr_enable_b = pwr_en_b_q;

endmodule

`default_nettype wire

//--- src/mem_pkg.sv
// Memory store package
// Sizes, latencies and the request and power structs shared by the
// power-gated 64 x 30 store built from two 64 x 16 register-file macros

`default_nettype none

package mem_pkg;

    // ----------------------------------------
    // Sizes and latencies
    // ----------------------------------------
    localparam int MEM_DEPTH       = 64;
    localparam int MEM_ADDR_W      = 6;
    localparam int MEM_DATA_W      = 30;
    localparam int MEM_HALF_W      = 16;
    // Enable-in to enable-out delay of one macro's power switch chain
    localparam int MEM_WAKE_CYCLES = 4;

    // ----------------------------------------
    // Stored macro word
    // ----------------------------------------
    // Parity sits in the top bit and covers the 15 data bits below it
    typedef struct packed {
        logic                  par;
        logic [MEM_HALF_W-2:0] data;
    } mem_half_f_s;

    // Raw view goes to the macro, field view is for encode and decode
    typedef union packed {
        logic [MEM_HALF_W-1:0] raw;
        mem_half_f_s           f;
    } mem_half_u;

    // ----------------------------------------
    // Requests and power controls
    // ----------------------------------------
    typedef struct packed {
        logic                  we;
        logic [MEM_ADDR_W-1:0] addr;
        mem_half_u             half;
    } mem_wr_req_s;

    typedef struct packed {
        logic                  re;
        logic [MEM_ADDR_W-1:0] addr;
    } mem_rd_req_s;

    // Power enable is active low, as on the macro pins
    typedef struct packed {
        logic isol_en;
        logic pwr_enable_b;
    } mem_pwr_s;

endpackage

`default_nettype wire
